// ==== rtl/exu_pkg.sv ====
`default_nettype none

package exu_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;     // Data, addresses and PC values
  typedef logic [4:0]      reg_idx_t;
  typedef logic [11:0]     csr_addr_t;

  //////////////////////////////////////////////////
  // Machine CSRs
  //////////////////////////////////////////////////

  localparam csr_addr_t csr_mstatus = 12'h300;
  localparam csr_addr_t csr_mtvec   = 12'h305;
  localparam csr_addr_t csr_mepc    = 12'h341;
  localparam csr_addr_t csr_mcause  = 12'h342;

  localparam word_t cause_ecall_m = 32'd11; // Environment call from M-mode

  //////////////////////////////////////////////////
  // Operation encodings
  //////////////////////////////////////////////////

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slt,
    alu_sltu,
    alu_sge,
    alu_sgeu,
    alu_pass_b
  } alu_op_e;

  typedef enum logic [2:0] {
    class_alu,
    class_branch,
    class_jal,
    class_jalr,
    class_load,
    class_store,
    class_system
  } op_class_e;

  typedef enum logic [2:0] {
    sys_csrrw,
    sys_csrrs,
    sys_csrrc,
    sys_ecall,
    sys_mret,
    sys_ebreak
  } sys_op_e;

  // Bus state machine of the execute control
  typedef enum logic [1:0] {
    st_idle,
    st_mem,
    st_done
  } ctrl_state_e;

endpackage

`default_nettype wire

// ==== rtl/csr_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface csr_if import exu_pkg::*; ();

  csr_addr_t addr;
  sys_op_e   cmd;
  word_t     wsrc;    // rs1 operand for the CSR forms
  word_t     trap_pc;
  logic      commit;  // One cycle wide, on the hand-off edge

  word_t     rdata;
  word_t     mtvec;
  word_t     mepc;

  modport ctrl (
    output addr, cmd, wsrc, trap_pc, commit,
    input  rdata, mtvec, mepc
  );

  modport csr (
    input  addr, cmd, wsrc, trap_pc, commit,
    output rdata, mtvec, mepc
  );

endinterface

`default_nettype wire

// ==== rtl/exu_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_alu import exu_pkg::*; (
  input  word_t   a_i,
  input  word_t   b_i,
  input  alu_op_e op_i,
  output word_t   res_o
);

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;

  assign shamt = b_i[4:0];
  assign lt_s  = $signed(a_i) < $signed(b_i);
  assign lt_u  = a_i < b_i;

  always_comb begin
    case (op_i)
      alu_add:    res_o = a_i + b_i;
      alu_sub:    res_o = a_i - b_i;
      alu_and:    res_o = a_i & b_i;
      alu_or:     res_o = a_i | b_i;
      alu_xor:    res_o = a_i ^ b_i;
      alu_sll:    res_o = a_i << shamt;
      alu_srl:    res_o = a_i >> shamt;
      alu_sra:    res_o = word_t'($signed(a_i) >>> shamt);
      alu_slt:    res_o = {{(xlen-1){1'b0}}, lt_s};
      alu_sltu:   res_o = {{(xlen-1){1'b0}}, lt_u};
      alu_sge:    res_o = {{(xlen-1){1'b0}}, ~lt_s}; // Used by BGE
      alu_sgeu:   res_o = {{(xlen-1){1'b0}}, ~lt_u};
      alu_pass_b: res_o = b_i;
      default:    res_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/exu_branch.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_branch import exu_pkg::*; (
  input  op_class_e class_i,
  input  sys_op_e   sys_op_i,
  input  alu_op_e   alu_op_i,
  input  word_t     pc_i,
  input  word_t     rs1_i,
  input  word_t     imm_i,
  input  word_t     alu_res_i,
  input  word_t     mtvec_i,
  input  word_t     mepc_i,
  output word_t     npc_o
);

  word_t seq_pc;
  word_t pc_rel;
  word_t jalr_sum;
  word_t jalr_tgt;
  logic  taken;

  assign seq_pc   = pc_i + 32'd4;
  assign pc_rel   = pc_i + imm_i;
  assign jalr_sum = rs1_i + imm_i;
  assign jalr_tgt = {jalr_sum[xlen-1:1], 1'b0};

  // BEQ compares through SUB, every other condition yields a nonzero flag
  always_comb begin
    taken = 1'b0;
    if (alu_op_i == alu_sub) begin
      taken = (alu_res_i == '0);
    end else if (alu_op_i inside {alu_xor, alu_slt, alu_sltu, alu_sge, alu_sgeu}) begin
      taken = |alu_res_i;
    end
  end

  always_comb begin
    npc_o = seq_pc;
    case (class_i)
      class_branch: begin
        if (taken) npc_o = pc_rel;
      end
      class_jal:  npc_o = pc_rel;
      class_jalr: npc_o = jalr_tgt;
      class_system: begin
        if (sys_op_i == sys_ecall) begin
          npc_o = mtvec_i;  // Trap entry
        end else if (sys_op_i == sys_mret) begin
          npc_o = mepc_i;
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/exu_csr_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_csr_file import exu_pkg::*; (
  input wire logic clk,
  input wire logic rst,
  csr_if.csr       csr_p
);

  word_t mstatus_q;
  word_t mtvec_q;
  word_t mepc_q;
  word_t mcause_q;
  word_t rdata;
  word_t wval;

  always_comb begin
    case (csr_p.addr)
      csr_mstatus: rdata = mstatus_q;
      csr_mtvec:   rdata = mtvec_q;
      csr_mepc:    rdata = mepc_q;
      csr_mcause:  rdata = mcause_q;
      default:     rdata = '0;  // Unimplemented CSRs read as zero
    endcase
  end

  // Read-modify-write value for the Zicsr forms
  always_comb begin
    case (csr_p.cmd)
      sys_csrrw: wval = csr_p.wsrc;
      sys_csrrs: wval = rdata | csr_p.wsrc;
      sys_csrrc: wval = rdata & ~csr_p.wsrc;
      default:   wval = rdata;
    endcase
  end

  //////////////////////////////////////////////////
  // Register update
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q <= '0;
      mtvec_q   <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else if (csr_p.commit) begin
      case (csr_p.cmd)
        sys_csrrw, sys_csrrs, sys_csrrc: begin
          case (csr_p.addr)
            csr_mstatus: mstatus_q <= wval;
            csr_mtvec:   mtvec_q   <= wval;
            csr_mepc:    mepc_q    <= wval;
            csr_mcause:  mcause_q  <= wval;
            default: ;
          endcase
        end
        sys_ecall: begin
          mepc_q   <= csr_p.trap_pc;
          mcause_q <= cause_ecall_m;
        end
        sys_mret: begin
          mstatus_q[3] <= mstatus_q[7]; // MIE takes MPIE back
          mstatus_q[7] <= 1'b1;
        end
        default: ;
      endcase
    end
  end

  assign csr_p.rdata = rdata;
  assign csr_p.mtvec = mtvec_q;
  assign csr_p.mepc  = mepc_q;

endmodule

`default_nettype wire

// ==== rtl/exu_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_ctrl import exu_pkg::*; (
  input  wire logic clk,
  input  wire logic rst,

  input  wire logic in_valid_i,
  output logic      in_ready_o,
  input  op_class_e class_i,
  input  alu_op_e   alu_op_i,
  input  sys_op_e   sys_op_i,
  input  word_t     rs1_i,
  input  word_t     rs2_i,
  input  word_t     imm_i,
  input  word_t     pc_i,
  input  csr_addr_t csr_addr_i,
  input  reg_idx_t  rd_i,

  output word_t     a_o,
  output word_t     b_o,
  output alu_op_e   alu_op_o,
  output op_class_e class_o,
  output sys_op_e   sys_op_o,
  output word_t     pc_o,
  output word_t     rs1_o,
  output word_t     imm_o,

  input  word_t     alu_res_i,
  input  word_t     npc_i,

  output logic      mem_req_o,
  output logic      mem_we_o,
  output word_t     mem_addr_o,
  output word_t     mem_wdata_o,
  input  word_t     mem_rdata_i,
  input  wire logic mem_ack_i,

  csr_if.ctrl       csr_p,

  output logic      out_valid_o,
  input  wire logic out_ready_i,
  output reg_idx_t  rd_o,
  output logic      rd_wen_o,
  output word_t     rd_wdata_o,
  output word_t     npc_o,
  output logic      ebreak_o
);

  ctrl_state_e state_q;

  op_class_e class_q;
  alu_op_e   alu_op_q;
  sys_op_e   sys_op_q;
  word_t     rs1_q;
  word_t     rs2_q;
  word_t     imm_q;
  word_t     pc_q;
  csr_addr_t csr_addr_q;
  reg_idx_t  rd_q;
  word_t     load_q;

  logic accept;
  logic handoff;
  logic is_mem;
  logic is_sys;

  assign in_ready_o  = (state_q == st_idle);
  assign out_valid_o = (state_q == st_done);
  assign accept      = in_valid_i & in_ready_o;
  assign handoff     = out_valid_o & out_ready_i;
  assign is_mem      = (class_i == class_load) || (class_i == class_store);
  assign is_sys      = (class_q == class_system);

  //////////////////////////////////////////////////
  // Bus state machine
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= st_idle;
    end else begin
      case (state_q)
        st_idle: if (accept) state_q <= is_mem ? st_mem : st_done;
        st_mem:  if (mem_ack_i) state_q <= st_done;
        st_done: if (out_ready_i) state_q <= st_idle;
        default: state_q <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      class_q    <= class_i;
      alu_op_q   <= alu_op_i;
      sys_op_q   <= sys_op_i;
      rs1_q      <= rs1_i;
      rs2_q      <= rs2_i;
      imm_q      <= imm_i;
      pc_q       <= pc_i;
      csr_addr_q <= csr_addr_i;
      rd_q       <= rd_i;
    end
    if (state_q == st_mem && mem_ack_i) load_q <= mem_rdata_i; // Read data valid on the ack edge
  end

  assign a_o      = rs1_q;
  assign b_o      = rs2_q;
  assign alu_op_o = alu_op_q;
  assign class_o  = class_q;
  assign sys_op_o = sys_op_q;
  assign pc_o     = pc_q;
  assign rs1_o    = rs1_q;
  assign imm_o    = imm_q;

  assign mem_req_o   = (state_q == st_mem);
  assign mem_we_o    = (class_q == class_store);
  assign mem_addr_o  = rs1_q + imm_q;
  assign mem_wdata_o = rs2_q;

  // CSR side effects land on the hand-off edge only
  assign csr_p.addr    = csr_addr_q;
  assign csr_p.cmd     = sys_op_q;
  assign csr_p.wsrc    = rs1_q;
  assign csr_p.trap_pc = pc_q;
  assign csr_p.commit  = handoff & is_sys;

  //////////////////////////////////////////////////
  // Result record
  //////////////////////////////////////////////////

  always_comb begin
    case (class_q)
      class_load:           rd_wdata_o = load_q;
      class_system:         rd_wdata_o = csr_p.rdata;  // Old CSR value
      class_jal, class_jalr: rd_wdata_o = pc_q + 32'd4;
      default:              rd_wdata_o = alu_res_i;
    endcase
  end

  always_comb begin
    rd_wen_o = 1'b1;
    if (class_q == class_store || class_q == class_branch) begin
      rd_wen_o = 1'b0;
    end else if (is_sys && sys_op_q inside {sys_ecall, sys_mret, sys_ebreak}) begin
      rd_wen_o = 1'b0;
    end
  end

  assign rd_o     = rd_q;
  assign npc_o    = npc_i;
  assign ebreak_o = is_sys && (sys_op_q == sys_ebreak);

endmodule

`default_nettype wire

// ==== rtl/exu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_top import exu_pkg::*; (
  input  wire logic clk,
  input  wire logic rst,

  input  wire logic in_valid_i,
  output logic      in_ready_o,
  input  op_class_e class_i,
  input  alu_op_e   alu_op_i,
  input  sys_op_e   sys_op_i,
  input  word_t     rs1_i,
  input  word_t     rs2_i,
  input  word_t     imm_i,
  input  word_t     pc_i,
  input  csr_addr_t csr_addr_i,
  input  reg_idx_t  rd_i,

  output logic      mem_req_o,
  output logic      mem_we_o,
  output word_t     mem_addr_o,
  output word_t     mem_wdata_o,
  input  word_t     mem_rdata_i,
  input  wire logic mem_ack_i,

  output logic      out_valid_o,
  input  wire logic out_ready_i,
  output reg_idx_t  rd_o,
  output logic      rd_wen_o,
  output word_t     rd_wdata_o,
  output word_t     npc_o,
  output logic      ebreak_o
);

  word_t     op_a;
  word_t     op_b;
  alu_op_e   alu_op;
  op_class_e op_class;
  sys_op_e   sys_op;
  word_t     op_pc;
  word_t     op_rs1;
  word_t     op_imm;
  word_t     alu_res;
  word_t     npc;

  csr_if csr_bus ();

  exu_ctrl u_ctrl (
    .clk         (clk),
    .rst         (rst),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .class_i     (class_i),
    .alu_op_i    (alu_op_i),
    .sys_op_i    (sys_op_i),
    .rs1_i       (rs1_i),
    .rs2_i       (rs2_i),
    .imm_i       (imm_i),
    .pc_i        (pc_i),
    .csr_addr_i  (csr_addr_i),
    .rd_i        (rd_i),
    .a_o         (op_a),
    .b_o         (op_b),
    .alu_op_o    (alu_op),
    .class_o     (op_class),
    .sys_op_o    (sys_op),
    .pc_o        (op_pc),
    .rs1_o       (op_rs1),
    .imm_o       (op_imm),
    .alu_res_i   (alu_res),
    .npc_i       (npc),
    .mem_req_o   (mem_req_o),
    .mem_we_o    (mem_we_o),
    .mem_addr_o  (mem_addr_o),
    .mem_wdata_o (mem_wdata_o),
    .mem_rdata_i (mem_rdata_i),
    .mem_ack_i   (mem_ack_i),
    .csr_p       (csr_bus.ctrl),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .rd_o        (rd_o),
    .rd_wen_o    (rd_wen_o),
    .rd_wdata_o  (rd_wdata_o),
    .npc_o       (npc_o),
    .ebreak_o    (ebreak_o)
  );

  exu_alu u_alu (
    .a_i   (op_a),
    .b_i   (op_b),
    .op_i  (alu_op),
    .res_o (alu_res)
  );

  exu_branch u_branch (
    .class_i   (op_class),
    .sys_op_i  (sys_op),
    .alu_op_i  (alu_op),
    .pc_i      (op_pc),
    .rs1_i     (op_rs1),
    .imm_i     (op_imm),
    .alu_res_i (alu_res),
    .mtvec_i   (csr_bus.mtvec),
    .mepc_i    (csr_bus.mepc),
    .npc_o     (npc)
  );

  exu_csr_file u_csr (
    .clk   (clk),
    .rst   (rst),
    .csr_p (csr_bus.csr)
  );

endmodule

`default_nettype wire

// ==== bench/exu_model.svh ====
`ifndef exu_model_svh
`define exu_model_svh

// Reference state of the execute stage
word_t mdl_mstatus;
word_t mdl_mtvec;
word_t mdl_mepc;
word_t mdl_mcause;
word_t mdl_mem [64];

// Every word of the memory gets a value built from its own index
function automatic word_t fill_word(logic [5:0] idx);
  return {idx, 2'b00, 8'h5a, 2'b11, idx, 8'(~idx)};
endfunction

task automatic reset_model();
  logic [5:0] idx;
  mdl_mstatus = '0;
  mdl_mtvec   = '0;
  mdl_mepc    = '0;
  mdl_mcause  = '0;
  idx = '0;
  repeat (64) begin
    mdl_mem[idx] = fill_word(idx);
    idx = idx + 6'd1;
  end
endtask

function automatic word_t alu_result(word_t a, word_t b, alu_op_e op);
  logic [4:0] sh;
  logic       less;
  sh   = b[4:0];
  less = (a[31] != b[31]) ? a[31] : (a < b); // Signed order from the sign bits
  case (op)
    alu_add:    return a + b;
    alu_sub:    return a - b;
    alu_and:    return a & b;
    alu_or:     return a | b;
    alu_xor:    return a ^ b;
    alu_sll:    return a << sh;
    alu_srl:    return a >> sh;
    alu_sra:    return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'd0);
    alu_slt:    return {31'd0, less};
    alu_sltu:   return {31'd0, a < b};
    alu_sge:    return {31'd0, !less};
    alu_sgeu:   return {31'd0, !(a < b)};
    alu_pass_b: return b;
    default:    return 32'd0;
  endcase
endfunction

function automatic logic branch_taken(alu_op_e op, word_t res);
  case (op)
    alu_sub:                                      return res == 32'd0; // BEQ
    alu_xor, alu_slt, alu_sltu, alu_sge, alu_sgeu: return res != 32'd0;
    default:                                      return 1'b0;
  endcase
endfunction

function automatic word_t csr_value(csr_addr_t addr);
  case (addr)
    csr_mstatus: return mdl_mstatus;
    csr_mtvec:   return mdl_mtvec;
    csr_mepc:    return mdl_mepc;
    csr_mcause:  return mdl_mcause;
    default:     return 32'd0;
  endcase
endfunction

function automatic word_t next_pc(op_class_e cls, sys_op_e sop, alu_op_e aop,
                                  word_t pc, word_t rs1, word_t rs2, word_t imm);
  word_t tgt;
  tgt = rs1 + imm;
  case (cls)
    class_branch: return branch_taken(aop, alu_result(rs1, rs2, aop)) ? pc + imm : pc + 32'd4;
    class_jal:    return pc + imm;
    class_jalr:   return tgt & 32'hffff_fffe;
    class_system: begin
      if (sop == sys_ecall) begin
        return mdl_mtvec;
      end else if (sop == sys_mret) begin
        return mdl_mepc;
      end
      return pc + 32'd4;
    end
    default:      return pc + 32'd4;
  endcase
endfunction

task automatic csr_store(csr_addr_t addr, word_t val);
  case (addr)
    csr_mstatus: mdl_mstatus = val;
    csr_mtvec:   mdl_mtvec   = val;
    csr_mepc:    mdl_mepc    = val;
    csr_mcause:  mdl_mcause  = val;
    default: ;
  endcase
endtask

// State changes that one instruction leaves behind at hand-off
task automatic retire_instr(op_class_e cls, sys_op_e sop, csr_addr_t addr,
                            word_t rs1, word_t rs2, word_t imm, word_t pc);
  word_t      old;
  word_t      ea;
  logic [5:0] idx;
  ea  = rs1 + imm;
  idx = ea[7:2];
  old = csr_value(addr);
  if (cls == class_store) begin
    mdl_mem[idx] = rs2;
  end else if (cls == class_system) begin
    case (sop)
      sys_csrrw: csr_store(addr, rs1);
      sys_csrrs: csr_store(addr, old | rs1);
      sys_csrrc: csr_store(addr, old & ~rs1);
      sys_ecall: begin
        mdl_mepc   = pc;
        mdl_mcause = cause_ecall_m;
      end
      sys_mret: mdl_mstatus = (mdl_mstatus & ~32'h88) | 32'h80 | (mdl_mstatus[7] ? 32'h8 : 32'h0);
      default: ;
    endcase
  end
endtask

`endif

// ==== bench/exu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_tb import exu_pkg::*; ();

  `include "exu_model.svh"

  localparam int num_instr  = 2000;
  localparam int timeout_ns = num_instr * 10 * 4;

  logic      clk;
  logic      rst;
  logic      in_valid_i;
  logic      in_ready_o;
  op_class_e class_i;
  alu_op_e   alu_op_i;
  sys_op_e   sys_op_i;
  word_t     rs1_i;
  word_t     rs2_i;
  word_t     imm_i;
  word_t     pc_i;
  csr_addr_t csr_addr_i;
  reg_idx_t  rd_i;
  logic      mem_req_o;
  logic      mem_we_o;
  word_t     mem_addr_o;
  word_t     mem_wdata_o;
  word_t     mem_rdata_i;
  logic      mem_ack_i;
  logic      out_valid_o;
  logic      out_ready_i;
  reg_idx_t  rd_o;
  logic      rd_wen_o;
  word_t     rd_wdata_o;
  word_t     npc_o;
  logic      ebreak_o;

  // Instruction held by the stage, as seen on its acceptance edge
  op_class_e acc_class;
  alu_op_e   acc_alu;
  sys_op_e   acc_sys;
  word_t     acc_rs1;
  word_t     acc_rs2;
  word_t     acc_imm;
  word_t     acc_pc;
  csr_addr_t acc_csr;
  reg_idx_t  acc_rd;

  reg_idx_t  held_rd;
  logic      held_wen;
  word_t     held_wdata;
  word_t     held_npc;
  logic      held_ebreak;

  word_t     bus_mem [64];
  logic      read_back;
  int        errors;
  int        checks;

  exu_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check_value(input word_t got, input word_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR @%0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  function automatic csr_addr_t pick_csr_addr();
    case ($urandom_range(0, 5))
      0:       return csr_mstatus;
      1:       return csr_mtvec;
      2:       return csr_mepc;
      3:       return csr_mcause;
      default: return 12'h7c0 + 12'($urandom_range(0, 15)); // Not implemented
    endcase
  endfunction

  task automatic make_instr();
    word_t addr;
    pc_i       = $urandom & 32'hffff_fffc;
    rs1_i      = $urandom;
    rs2_i      = ($urandom_range(0, 3) == 0) ? rs1_i : $urandom; // Equal operands for BEQ
    imm_i      = $urandom;
    rd_i       = 5'($urandom_range(0, 31));
    alu_op_i   = alu_op_e'(4'($urandom_range(0, 12)));
    class_i    = op_class_e'(3'($urandom_range(0, 6)));
    sys_op_i   = sys_op_e'(3'($urandom_range(0, 5)));
    csr_addr_i = pick_csr_addr();
    if (read_back) begin
      // Look at the trap registers right after an ECALL
      class_i    = class_system;
      sys_op_i   = sys_csrrs;
      rs1_i      = '0;
      csr_addr_i = ($urandom_range(0, 1) == 0) ? csr_mepc : csr_mcause;
    end
    read_back = (class_i == class_system) && (sys_op_i == sys_ecall);
    if (class_i inside {class_load, class_store}) begin
      addr  = 32'($urandom_range(0, 63)) << 2;
      imm_i = addr - rs1_i;
    end
  endtask

  task automatic check_stable();
    check_value(32'(rd_o), 32'(held_rd), "rd_o under back-pressure");
    check_value(32'(rd_wen_o), 32'(held_wen), "rd_wen_o under back-pressure");
    check_value(rd_wdata_o, held_wdata, "rd_wdata_o under back-pressure");
    check_value(npc_o, held_npc, "npc_o under back-pressure");
    check_value(32'(ebreak_o), 32'(held_ebreak), "ebreak_o under back-pressure");
  endtask

  task automatic check_handoff();
    word_t ea;
    word_t exp_wdata;
    logic  exp_wen;
    logic  no_write;
    ea       = acc_rs1 + acc_imm;
    no_write = (acc_class == class_system) && (acc_sys inside {sys_ecall, sys_mret, sys_ebreak});
    exp_wen  = !((acc_class inside {class_store, class_branch}) || no_write);
    case (acc_class)
      class_load:            exp_wdata = mdl_mem[ea[7:2]];
      class_system:          exp_wdata = csr_value(acc_csr); // Old value
      class_jal, class_jalr: exp_wdata = acc_pc + 32'd4;
      default:               exp_wdata = alu_result(acc_rs1, acc_rs2, acc_alu);
    endcase
    check_value(32'(rd_o), 32'(acc_rd), "rd_o");
    check_value(32'(rd_wen_o), 32'(exp_wen), "rd_wen_o");
    if (exp_wen) begin
      check_value(rd_wdata_o, exp_wdata, "rd_wdata_o");
    end
    check_value(npc_o, next_pc(acc_class, acc_sys, acc_alu, acc_pc, acc_rs1, acc_rs2, acc_imm),
                "npc_o");
    check_value(32'(ebreak_o), 32'(acc_class == class_system && acc_sys == sys_ebreak),
                "ebreak_o");
    retire_instr(acc_class, acc_sys, acc_csr, acc_rs1, acc_rs2, acc_imm, acc_pc);
  endtask

  //////////////////////////////////////////////////
  // Memory responder
  //////////////////////////////////////////////////

  initial begin : mem_responder
    logic [5:0] idx;
    mem_ack_i   = 1'b0;
    mem_rdata_i = '0;
    forever begin
      @(posedge clk);
      #1;
      mem_ack_i   = 1'b0;
      mem_rdata_i = $urandom;  // Junk outside the ack cycle
      if (mem_req_o) begin
        check_value(32'(mem_we_o), 32'(acc_class == class_store), "mem_we_o");
        check_value(mem_addr_o, acc_rs1 + acc_imm, "mem_addr_o");
        if (acc_class == class_store) begin
          check_value(mem_wdata_o, acc_rs2, "mem_wdata_o");
        end
        repeat ($urandom_range(0, 3)) begin
          @(posedge clk);
          #1;
          mem_rdata_i = $urandom;
          check_value(32'(mem_req_o), 32'd1, "mem_req_o before the ack");
        end
        idx = mem_addr_o[7:2];
        if (mem_we_o) begin
          bus_mem[idx] = mem_wdata_o;
        end else begin
          mem_rdata_i = bus_mem[idx];
        end
        mem_ack_i = 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus and checks
  //////////////////////////////////////////////////

  initial begin : stimulus
    logic [5:0] idx;
    int         sent;
    int         handed;
    logic       have_instr;
    logic       just_accepted;
    logic       just_handed;
    logic       stalled;
    void'($urandom(51219));
    errors = 0;
    checks = 0;
    sent = 0;
    handed = 0;
    have_instr = 1'b0;
    just_accepted = 1'b0;
    just_handed = 1'b0;
    stalled = 1'b0;
    read_back = 1'b0;
    rst = 1'b1;
    in_valid_i = 1'b0;
    out_ready_i = 1'b0;
    class_i = class_alu;
    alu_op_i = alu_add;
    sys_op_i = sys_csrrw;
    rs1_i = '0;
    rs2_i = '0;
    imm_i = '0;
    pc_i = '0;
    csr_addr_i = '0;
    rd_i = '0;
    reset_model();
    idx = '0;
    repeat (64) begin
      bus_mem[idx] = fill_word(idx);
      idx = idx + 6'd1;
    end
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    check_value(32'(out_valid_o), 32'd0, "out_valid_o after reset");
    check_value(32'(mem_req_o), 32'd0, "mem_req_o after reset");
    check_value(32'(in_ready_o), 32'd1, "in_ready_o after reset");
    while (handed < num_instr) begin
      @(posedge clk);
      #1;
      out_ready_i = ($urandom_range(0, 3) != 0);
      if (sent < num_instr) begin
        if (!have_instr) begin
          make_instr();
          have_instr = 1'b1;
        end
        in_valid_i = ($urandom_range(0, 3) != 0);
      end else begin
        in_valid_i = 1'b0;
      end
      @(negedge clk);
      if (just_accepted) begin
        if (acc_class inside {class_load, class_store}) begin
          check_value(32'(mem_req_o), 32'd1, "mem_req_o one cycle after accept");
        end else begin
          check_value(32'(out_valid_o), 32'd1, "out_valid_o one cycle after accept");
        end
        just_accepted = 1'b0;
      end
      if (just_handed) begin
        check_value(32'(in_ready_o), 32'd1, "in_ready_o one cycle after hand-off");
        just_handed = 1'b0;
      end
      if (out_valid_o) begin
        check_value(32'(in_ready_o), 32'd0, "in_ready_o while a result waits");
        if (stalled) begin
          check_stable();
        end
        stalled     = !out_ready_i;
        held_rd     = rd_o;
        held_wen    = rd_wen_o;
        held_wdata  = rd_wdata_o;
        held_npc    = npc_o;
        held_ebreak = ebreak_o;
        if (out_ready_i) begin
          check_handoff();
          just_handed = 1'b1;
          handed++;
        end
      end
      if (in_valid_i && in_ready_o) begin  // Accepted on the coming edge
        acc_class = class_i;
        acc_alu   = alu_op_i;
        acc_sys   = sys_op_i;
        acc_rs1   = rs1_i;
        acc_rs2   = rs2_i;
        acc_imm   = imm_i;
        acc_pc    = pc_i;
        acc_csr   = csr_addr_i;
        acc_rd    = rd_i;
        have_instr = 1'b0;
        just_accepted = 1'b1;
        sent++;
      end
    end
    $display("Instructions: %0d, checks: %0d, errors: %0d", handed, checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(timeout_ns);
    $display("Timeout: the run did not finish within %0d ns", timeout_ns);
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+bench
rtl/exu_pkg.sv
rtl/csr_if.sv
rtl/exu_alu.sv
rtl/exu_branch.sv
rtl/exu_csr_file.sv
rtl/exu_ctrl.sv
rtl/exu_top.sv
bench/exu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the execute stage testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps --top-module exu_tb -f all.f -o exu_sim \
  && ./obj_dir/exu_sim | tee /dev/stderr | grep -q "All tests passed" \
  && echo "Simulation run passed" \
  || { echo "Simulation run failed"; exit 1; }
